// File: hdl/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;                     // Data width
    localparam int REG_ADDR_W = 5;                // Register index width

    typedef logic [XLEN-1:0] data_t;              // Data word
    typedef logic [31:0] inst_t;                  // Instruction word
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;    // Register index

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add = 4'd0,                           // Reset value
        alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and,
        alu_pass_b                                // LUI
    } alu_op_e;

    typedef enum logic {opa_rs1, opa_pc} opa_sel_e;
    typedef enum logic {opb_rs2, opb_imm} opb_sel_e;

    typedef enum logic [3:0] {
        br_none = 4'd0,
        br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu,
        br_jal, br_jalr
    } br_op_e;

    typedef enum logic {wb_alu, wb_pc4} wb_sel_e;

    typedef struct packed {
        data_t     pc;                            // Instruction address
        data_t     imm;                           // Selected immediate
        data_t     rs1_data;
        data_t     rs2_data;
        reg_addr_t rd;
        logic      rd_we;                         // Cleared on bubble, branch, x0
        logic      illegal;
        opa_sel_e  opa_sel;
        opb_sel_e  opb_sel;
        alu_op_e   alu_op;
        br_op_e    br_op;
        wb_sel_e   wb_sel;
    } idex_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      rd_we;
        data_t     alu_res;
        data_t     pc_plus4;                      // Link value for jumps
        wb_sel_e   wb_sel;
    } exwb_t;

    typedef struct packed {
        logic      en;                            // Write strobe
        reg_addr_t addr;
        data_t     data;
    } wb_t;

endpackage

// File: hdl/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
    input  logic              i_clock,
    input  logic              i_rst,
    input  rv_pkg::reg_addr_t i_rs1_addr,     // Read port A
    input  rv_pkg::reg_addr_t i_rs2_addr,     // Read port B
    input  rv_pkg::wb_t       i_wb,           // Write port
    output rv_pkg::data_t     o_rs1_data,
    output rv_pkg::data_t     o_rs2_data
);

    rv_pkg::data_t regs [32];                 // Entry 0 never written

    // x0, then same-cycle write bypass, then array
    function automatic rv_pkg::data_t read_port(input rv_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_wb.en && (i_wb.addr == addr)) begin
            return i_wb.data;                 // Write-through
        end
        return regs[addr];
    endfunction

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.en && (i_wb.addr != '0)) begin
            regs[i_wb.addr] <= i_wb.data;     // x0 stays zero
        end
    end

    always_comb begin
        o_rs1_data = read_port(i_rs1_addr);
        o_rs2_data = read_port(i_rs2_addr);
    end

endmodule

// File: hdl/rv_decode.sv
`timescale 1ns/100ps

module rv_decode (
    input  logic              i_inst_valid,   // Fetch strobe
    input  rv_pkg::inst_t     i_inst,
    input  rv_pkg::data_t     i_pc,
    input  rv_pkg::data_t     i_rs1_data,     // From register file
    input  rv_pkg::data_t     i_rs2_data,
    output rv_pkg::reg_addr_t o_rs1_addr,
    output rv_pkg::reg_addr_t o_rs2_addr,
    output rv_pkg::idex_t     o_idex
);

    rv_pkg::opcode_e   opcode;
    rv_pkg::alu_op_e   alu_f3;                // ALU op from funct3/funct7
    rv_pkg::reg_addr_t rd;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    rv_pkg::data_t     imm_i;
    rv_pkg::data_t     imm_u;
    rv_pkg::data_t     imm_b;
    rv_pkg::data_t     imm_j;

    assign opcode     = rv_pkg::opcode_e'(i_inst[6:0]);
    assign rd         = i_inst[11:7];
    assign funct3     = i_inst[14:12];
    assign o_rs1_addr = i_inst[19:15];
    assign o_rs2_addr = i_inst[24:20];
    assign funct7     = i_inst[31:25];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_u = {i_inst[31:12], 12'b0};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                    i_inst[11:8], 1'b0};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                    i_inst[30:21], 1'b0};

    always_comb begin
        case (funct3)
            3'b000:  alu_f3 = (opcode == rv_pkg::opc_op && funct7[5]) ?
                              rv_pkg::alu_sub : rv_pkg::alu_add;   // sub only for OP
            3'b001:  alu_f3 = rv_pkg::alu_sll;
            3'b010:  alu_f3 = rv_pkg::alu_slt;
            3'b011:  alu_f3 = rv_pkg::alu_sltu;
            3'b100:  alu_f3 = rv_pkg::alu_xor;
            3'b101:  alu_f3 = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  alu_f3 = rv_pkg::alu_or;
            default: alu_f3 = rv_pkg::alu_and;
        endcase
    end

    always_comb begin
        o_idex          = '0;
        o_idex.pc       = i_pc;
        o_idex.rs1_data = i_rs1_data;
        o_idex.rs2_data = i_rs2_data;
        o_idex.rd       = rd;
        o_idex.rd_we    = (rd != '0);             // No writes to x0
        o_idex.imm      = imm_i;                  // Default I-type
        o_idex.opa_sel  = rv_pkg::opa_rs1;
        o_idex.opb_sel  = rv_pkg::opb_rs2;
        o_idex.alu_op   = rv_pkg::alu_add;
        o_idex.br_op    = rv_pkg::br_none;
        o_idex.wb_sel   = rv_pkg::wb_alu;
        case (opcode)
            rv_pkg::opc_op: o_idex.alu_op = alu_f3;
            rv_pkg::opc_op_imm: begin
                o_idex.opb_sel = rv_pkg::opb_imm;
                o_idex.alu_op  = alu_f3;
            end
            rv_pkg::opc_lui: begin
                o_idex.imm     = imm_u;
                o_idex.opb_sel = rv_pkg::opb_imm;
                o_idex.alu_op  = rv_pkg::alu_pass_b;
            end
            rv_pkg::opc_auipc: begin
                o_idex.imm     = imm_u;
                o_idex.opa_sel = rv_pkg::opa_pc;  // pc + imm
                o_idex.opb_sel = rv_pkg::opb_imm;
            end
            rv_pkg::opc_jal: begin
                o_idex.imm    = imm_j;
                o_idex.br_op  = rv_pkg::br_jal;
                o_idex.wb_sel = rv_pkg::wb_pc4;   // Link
            end
            rv_pkg::opc_jalr: begin
                o_idex.br_op  = rv_pkg::br_jalr;
                o_idex.wb_sel = rv_pkg::wb_pc4;
            end
            rv_pkg::opc_branch: begin
                o_idex.imm   = imm_b;
                o_idex.rd_we = 1'b0;              // Branches never write
                case (funct3)
                    3'b000:  o_idex.br_op = rv_pkg::br_eq;
                    3'b001:  o_idex.br_op = rv_pkg::br_ne;
                    3'b100:  o_idex.br_op = rv_pkg::br_lt;
                    3'b101:  o_idex.br_op = rv_pkg::br_ge;
                    3'b110:  o_idex.br_op = rv_pkg::br_ltu;
                    3'b111:  o_idex.br_op = rv_pkg::br_geu;
                    default: o_idex.br_op = rv_pkg::br_none;
                endcase
            end
            default: begin
                o_idex.rd_we   = 1'b0;
                o_idex.illegal = 1'b1;            // Loads, stores, system, ...
            end
        endcase
        if (!i_inst_valid) begin
            o_idex.rd_we   = 1'b0;                // Bubble
            o_idex.illegal = 1'b0;
            o_idex.br_op   = rv_pkg::br_none;
        end
    end

endmodule

// File: hdl/rv_idex_reg.sv
`timescale 1ns/100ps

module rv_idex_reg (
    input  logic          i_clock,
    input  logic          i_rst,
    input  logic          i_flush,        // Redirect from execute
    input  rv_pkg::idex_t i_idex,
    output rv_pkg::idex_t o_idex
);

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_idex <= '0;                 // alu_op comes out as add
        end else begin
            o_idex <= i_idex;
            if (i_flush) begin
                // Squash the shadow instruction, keep its payload
                o_idex.rd_we   <= 1'b0;
                o_idex.illegal <= 1'b0;
                o_idex.br_op   <= rv_pkg::br_none;
            end
        end
    end

endmodule

// File: hdl/rv_execute.sv
`timescale 1ns/100ps

module rv_execute (
    input  rv_pkg::idex_t i_idex,
    output rv_pkg::exwb_t o_exwb,
    output logic          o_redirect,     // Taken branch or jump
    output rv_pkg::data_t o_target,
    output logic          o_illegal
);

    rv_pkg::data_t op_a;
    rv_pkg::data_t op_b;
    rv_pkg::data_t alu_res;
    rv_pkg::data_t rs1;
    rv_pkg::data_t rs2;
    rv_pkg::data_t jalr_sum;
    logic [4:0]    shamt;
    logic          taken;

    assign rs1   = i_idex.rs1_data;
    assign rs2   = i_idex.rs2_data;
    assign op_a  = (i_idex.opa_sel == rv_pkg::opa_pc) ? i_idex.pc : rs1;
    assign op_b  = (i_idex.opb_sel == rv_pkg::opb_imm) ? i_idex.imm : rs2;
    assign shamt = op_b[4:0];                 // Low 5 bits only

    always_comb begin
        case (i_idex.alu_op)
            rv_pkg::alu_sub:    alu_res = op_a - op_b;
            rv_pkg::alu_sll:    alu_res = op_a << shamt;
            rv_pkg::alu_slt:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu:   alu_res = {31'b0, op_a < op_b};
            rv_pkg::alu_xor:    alu_res = op_a ^ op_b;
            rv_pkg::alu_srl:    alu_res = op_a >> shamt;
            rv_pkg::alu_sra:    alu_res = rv_pkg::data_t'($signed(op_a) >>> shamt);
            rv_pkg::alu_or:     alu_res = op_a | op_b;
            rv_pkg::alu_and:    alu_res = op_a & op_b;
            rv_pkg::alu_pass_b: alu_res = op_b;   // LUI
            default:            alu_res = op_a + op_b;
        endcase
    end

    // Branch condition on the raw register values
    always_comb begin
        case (i_idex.br_op)
            rv_pkg::br_eq:   taken = (rs1 == rs2);
            rv_pkg::br_ne:   taken = (rs1 != rs2);
            rv_pkg::br_lt:   taken = ($signed(rs1) < $signed(rs2));
            rv_pkg::br_ge:   taken = ($signed(rs1) >= $signed(rs2));
            rv_pkg::br_ltu:  taken = (rs1 < rs2);
            rv_pkg::br_geu:  taken = (rs1 >= rs2);
            rv_pkg::br_jal,
            rv_pkg::br_jalr: taken = 1'b1;        // Jumps always redirect
            default:         taken = 1'b0;
        endcase
    end

    assign jalr_sum   = rs1 + i_idex.imm;
    assign o_target   = (i_idex.br_op == rv_pkg::br_jalr) ?
                        {jalr_sum[31:1], 1'b0} : i_idex.pc + i_idex.imm;
    assign o_redirect = taken;
    assign o_illegal  = i_idex.illegal;

    assign o_exwb.rd       = i_idex.rd;
    assign o_exwb.rd_we    = i_idex.rd_we;
    assign o_exwb.alu_res  = alu_res;
    assign o_exwb.pc_plus4 = i_idex.pc + 32'd4;   // Link address
    assign o_exwb.wb_sel   = i_idex.wb_sel;

endmodule

// File: hdl/rv_result.sv
`timescale 1ns/100ps

module rv_result (
    input  logic          i_clock,
    input  logic          i_rst,
    input  rv_pkg::exwb_t i_exwb,
    output rv_pkg::wb_t   o_wb
);

    rv_pkg::exwb_t exwb_q;                    // EX/WB stage register

    always_ff @(posedge i_clock) begin
        exwb_q <= i_exwb;
        if (i_rst) begin
            exwb_q.rd_we <= 1'b0;             // Only the enable is cleared
        end
    end

    assign o_wb.en   = exwb_q.rd_we;
    assign o_wb.addr = exwb_q.rd;
    assign o_wb.data = (exwb_q.wb_sel == rv_pkg::wb_pc4) ?
                       exwb_q.pc_plus4 : exwb_q.alu_res;    // Link or ALU

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/100ps

module rv_core (
    input  logic          i_clock,
    input  logic          i_rst,
    input  logic          i_inst_valid,   // Low means bubble
    input  rv_pkg::inst_t i_inst,
    input  rv_pkg::data_t i_pc,
    output rv_pkg::wb_t   o_wb,           // Register write, cycle n+2
    output logic          o_redirect,     // Pulse in cycle n+1
    output rv_pkg::data_t o_target,
    output logic          o_illegal
);

    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::data_t     rs1_data;
    rv_pkg::data_t     rs2_data;
    rv_pkg::idex_t     id_idex;           // Decode output
    rv_pkg::idex_t     ex_idex;           // ID/EX register output
    rv_pkg::exwb_t     ex_exwb;

    rv_decode u_decode (
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_rs1_addr   (rs1_addr),
        .o_rs2_addr   (rs2_addr),
        .o_idex       (id_idex)
    );

    rv_regfile u_regfile (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_wb       (o_wb),               // Write port from result stage
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_idex_reg u_idex_reg (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .i_flush (o_redirect),            // Kill the shadow instruction
        .i_idex  (id_idex),
        .o_idex  (ex_idex)
    );

    rv_execute u_execute (
        .i_idex     (ex_idex),
        .o_exwb     (ex_exwb),
        .o_redirect (o_redirect),
        .o_target   (o_target),
        .o_illegal  (o_illegal)
    );

    rv_result u_result (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .i_exwb  (ex_exwb),
        .o_wb    (o_wb)
    );

endmodule

// File: tb/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb;

    localparam int MAXS  = 2048;              // Slot capacity
    localparam int NRAND = 300;               // Random instructions after preload

    logic          clock;
    logic          rst;
    logic          i_inst_valid;
    rv_pkg::inst_t i_inst;
    rv_pkg::data_t i_pc;
    rv_pkg::wb_t   o_wb;
    logic          o_redirect;
    rv_pkg::data_t o_target;
    logic          o_illegal;

    logic        prog_valid [MAXS];           // Fetch stream per slot
    logic [31:0] prog_inst [MAXS];
    logic [31:0] prog_pc [MAXS];
    logic        exp_en [MAXS];               // Expected outputs per check slot
    logic [4:0]  exp_addr [MAXS];
    logic [31:0] exp_data [MAXS];
    logic        exp_redir [MAXS];
    logic [31:0] exp_target [MAXS];
    logic        exp_ill [MAXS];
    logic [31:0] xreg [32];                   // Model register file
    logic [31:0] rng_state;
    logic [31:0] pc;                          // Model fetch address
    int          nslot;
    int          slot;                        // Slot on the inputs now
    int          chk;                         // Slot whose results are checked
    int          err_wb;
    int          err_br;
    int          err_ill;
    bit          gen_done;

    logic        e_en;
    logic [4:0]  e_addr;
    logic [31:0] e_data;
    logic        e_redir;
    logic [31:0] e_target;
    logic        e_ill;

    assign e_en     = exp_en[chk];
    assign e_addr   = exp_addr[chk];
    assign e_data   = exp_data[chk];
    assign e_redir  = exp_redir[chk];
    assign e_target = exp_target[chk];
    assign e_ill    = exp_ill[chk];

    rv_core u_dut (
        .i_clock      (clock),
        .i_rst        (rst),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .o_wb         (o_wb),
        .o_redirect   (o_redirect),
        .o_target     (o_target),
        .o_illegal    (o_illegal)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;            // 4 ns period
    end

    always @(posedge clock) begin
        chk <= slot;                          // Lags the inputs by one edge
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] encode(input rv_pkg::opcode_e opc, input logic [4:0] rd,
            input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
            input logic [6:0] f7, input logic [31:0] imm);
        case (opc)
            rv_pkg::opc_op:     return {f7, rs2, rs1, f3, rd, opc};
            rv_pkg::opc_op_imm,
            rv_pkg::opc_jalr:   return {imm[11:0], rs1, f3, rd, opc};
            rv_pkg::opc_lui,
            rv_pkg::opc_auipc:  return {imm[31:12], rd, opc};
            rv_pkg::opc_branch: return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
            default:            return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
        endcase
    endfunction

    // Integer result by funct3 with alt as funct7 bit 5
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
            input logic is_op, input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return (is_op && alt) ? a - b : a + b;    // sub exists only for OP
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];          // Arithmetic
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
            input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic emit(input logic valid, input logic [31:0] inst);
        prog_valid[nslot] = valid;
        prog_inst[nslot]  = inst;
        prog_pc[nslot]    = pc;
        nslot++;
        if (valid) begin
            pc = pc + 32'd4;
        end
    endtask

    // Write of the instruction about to be emitted, seen one check slot later
    task automatic write_reg(input logic [4:0] rd, input logic [31:0] val);
        exp_en[nslot + 1]   = (rd != '0);
        exp_addr[nslot + 1] = rd;
        exp_data[nslot + 1] = val;
        if (rd != '0) begin
            xreg[rd] = val;
        end
    endtask

    task automatic gen_instr();
        logic [31:0] r;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] iimm;
        logic [31:0] uimm;
        logic [31:0] bimm;
        logic [31:0] jimm;
        logic [31:0] inst;
        logic [31:0] shadow;
        logic [31:0] target;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        taken;
        r      = next_random();
        imm    = next_random();
        rd     = r[4:0];
        rs1    = r[9:5];
        rs2    = r[19] ? r[9:5] : r[14:10];  // Equal sources now and then
        f3     = r[17:15];
        f7     = r[18] ? 7'h20 : 7'h00;
        a      = xreg[rs1];
        b      = xreg[rs2];
        iimm   = {{20{imm[11]}}, imm[11:0]};
        uimm   = {imm[31:12], 12'b0};
        bimm   = {{19{imm[12]}}, imm[12:1], 1'b0};
        jimm   = {{11{imm[20]}}, imm[20:1], 1'b0};
        taken  = 1'b0;
        target = '0;
        case (r[31:29])
            3'd0: begin
                write_reg(rd, alu_ref(f3, f7[5], 1'b1, a, b));
                inst = encode(rv_pkg::opc_op, rd, f3, rs1, rs2, f7, '0);
            end
            3'd1: begin
                write_reg(rd, alu_ref(f3, imm[10], 1'b0, a, iimm));
                inst = encode(rv_pkg::opc_op_imm, rd, f3, rs1, rs2, f7, iimm);
            end
            3'd2: begin
                write_reg(rd, uimm);
                inst = encode(rv_pkg::opc_lui, rd, f3, rs1, rs2, f7, uimm);
            end
            3'd3: begin
                write_reg(rd, pc + uimm);
                inst = encode(rv_pkg::opc_auipc, rd, f3, rs1, rs2, f7, uimm);
            end
            3'd4, 3'd5: begin
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;             // No branch with funct3 2 or 3
                end
                taken  = branch_ref(f3, a, b);
                target = pc + bimm;
                inst   = encode(rv_pkg::opc_branch, rd, f3, rs1, rs2, f7, bimm);
            end
            3'd6: begin
                taken = 1'b1;
                write_reg(rd, pc + 32'd4);   // Link
                if (r[20]) begin
                    target = (a + iimm) & ~32'd1;
                    inst   = encode(rv_pkg::opc_jalr, rd, 3'd0, rs1, rs2, f7, iimm);
                end else begin
                    target = pc + jimm;
                    inst   = encode(rv_pkg::opc_jal, rd, f3, rs1, rs2, f7, jimm);
                end
            end
            default: begin
                exp_ill[nslot] = 1'b1;
                inst = {imm[31:7], r[21] ? 7'b0100011 : 7'b0000011};    // Store or load
            end
        endcase
        exp_redir[nslot]  = taken;
        exp_target[nslot] = target;
        emit(1'b1, inst);
        if (taken) begin
            // Flushed shadow of jump, load or ALU op leaves the model alone
            case (r[23:22])
                2'd0:    shadow = encode(rv_pkg::opc_jal, rd, f3, rs1, rs2, f7, jimm);
                2'd1:    shadow = {imm[31:7], 7'b0000011};             // Load
                default: shadow = encode(rv_pkg::opc_op_imm, rs2, f3, rs1, rs2, f7, imm);
            endcase
            emit(1'b1, shadow);
            pc = target;
        end else begin
            emit(1'b0, '0);                   // Two-slot spacing
        end
    endtask

    task automatic build_program();
        logic [31:0] v;
        rng_state = 32'd26984;
        pc        = 32'h0000_1000;
        nslot     = 1;                        // Slot 0 stands for reset
        for (int i = 0; i < MAXS; i++) begin
            prog_valid[i] = 1'b0;
            exp_en[i]     = 1'b0;
            exp_addr[i]   = '0;
            exp_data[i]   = '0;
            exp_redir[i]  = 1'b0;
            exp_target[i] = '0;
            exp_ill[i]    = 1'b0;
        end
        for (int i = 0; i < 32; i++) begin
            xreg[i] = '0;
        end
        for (int r = 1; r < 32; r++) begin
            v = next_random();
            write_reg(5'(r), {v[31:12], 12'b0});
            emit(1'b1, encode(rv_pkg::opc_lui, 5'(r), 3'd0, 5'd0, 5'd0, 7'd0, v));
            emit(1'b0, '0);
            // ADDI reads the LUI result through the write bypass
            write_reg(5'(r), xreg[r] + {{20{v[11]}}, v[11:0]});
            emit(1'b1, encode(rv_pkg::opc_op_imm, 5'(r), 3'd0, 5'(r), 5'd0, 7'd0, v));
            emit(1'b0, '0);
        end
        for (int i = 0; i < NRAND; i++) begin
            gen_instr();
        end
    endtask

    // Outputs change only after the rising edge
    assert property (@(negedge clock) o_wb.en == e_en)
    else begin
        err_wb++;
        $display("error %0t o_wb.en expected %0b actual %0b", $time, e_en, o_wb.en);
    end

    assert property (@(negedge clock) !e_en || o_wb.addr == e_addr)
    else begin
        err_wb++;
        $display("error %0t o_wb.addr expected %0d actual %0d", $time, e_addr, o_wb.addr);
    end

    assert property (@(negedge clock) !e_en || o_wb.data == e_data)
    else begin
        err_wb++;
        $display("error %0t o_wb.data expected %h actual %h", $time, e_data, o_wb.data);
    end

    assert property (@(negedge clock) o_redirect == e_redir)
    else begin
        err_br++;
        $display("error %0t o_redirect expected %0b actual %0b", $time, e_redir, o_redirect);
    end

    assert property (@(negedge clock) !e_redir || o_target == e_target)
    else begin
        err_br++;
        $display("error %0t o_target expected %h actual %h", $time, e_target, o_target);
    end

    assert property (@(negedge clock) o_illegal == e_ill)
    else begin
        err_ill++;
        $display("error %0t o_illegal expected %0b actual %0b", $time, e_ill, o_illegal);
    end

    initial begin
        wait (gen_done);
        #((nslot * 4 + 100) * 4);             // Program length times 4 plus 100 cycles
        $display("Timeout: the program did not finish within the expected time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        i_pc         = '0;
        slot         = 0;
        err_wb       = 0;
        err_br       = 0;
        err_ill      = 0;
        build_program();
        gen_done = 1'b1;
        repeat (3) @(negedge clock);
        rst = 1'b0;
        for (int s = 1; s < nslot + 3; s++) begin
            slot         = s;
            i_inst_valid = (s < nslot) ? prog_valid[s] : 1'b0;
            i_inst       = (s < nslot) ? prog_inst[s] : '0;
            i_pc         = (s < nslot) ? prog_pc[s] : '0;
            @(negedge clock);
        end
        repeat (2) @(negedge clock);          // Drain
        @(posedge clock);                     // Last falling-edge checks settle
        $display("Errors: write-back %0d, redirect %0d, illegal %0d", err_wb, err_br, err_ill);
        if (err_wb + err_br + err_ill == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: rv_core.f
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_idex_reg.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_core.sv
tb/rv_core_tb.sv

// File: Makefile
TOP = rv_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f rv_core.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f rv_core.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q -x -F '** PASS **'

clean:
	rm -rf obj_dir
